// ==== Makefile ====
# Verilator build and run for the spi control bank testbench

VERILATOR ?= verilator
TOP       ?= tb_spi_ctrl
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0

SOURCES := $(wildcard hdl/*.sv hdl/*.svh verif/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/ctrl_reg_bank.sv ====
////////////////////////////////////////////////////////////
// board control register bank
// applies write and command frames to the control registers
// and returns the addressed register for readback
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "spi_bank_cfg.svh"

module ctrl_reg_bank (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      frame_valid,
  input  logic                      addr_valid,
  input  logic [7:0]                frame_addr,
  input  spi_bank_pkg::frame_data_u frame_data,
  output logic [7:0]                rd_data,
  output logic [7:0]                spi_mux,
  output spi_bank_pkg::nibble_t     led,
  output spi_bank_pkg::nibble_t     oe_4094,
  output spi_bank_pkg::nibble_t     dac_ctl,
  output spi_bank_pkg::nibble_t     adc_ctl
);

  import spi_bank_pkg::*;

  // readback value for the current address
  logic [7:0] rd_mux;

  ////////////////////////////////////////////////////////////
  // set/clear nibble rule

  // overlap of set and clear toggles just those bits,
  // the rest of the byte is ignored then
  function automatic nibble_t nibble_update(input nibble_t cur, input frame_data_u fd);
    nibble_t overlap;
    overlap = fd.sc.set & fd.sc.clear;
    if (overlap != '0)
      nibble_update = cur ^ overlap;
    else
      // set first, clear wins
      nibble_update = (cur | fd.sc.set) & ~fd.sc.clear;
  endfunction

  ////////////////////////////////////////////////////////////
  // register writes and commands

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      led     <= '0;
      oe_4094 <= '0;
      dac_ctl <= `DAC_RESET_VALUE;
      adc_ctl <= '0;
      spi_mux <= '0;
    end
    else if (frame_valid)
    begin
      case (frame_addr)
        `REG_LED:
          led <= nibble_update(led, frame_data);
        // whole byte, selects a pass-through line
        `REG_SPI_MUX:
          spi_mux <= frame_data.raw;
        `REG_4094:
          oe_4094 <= nibble_update(oe_4094, frame_data);
        `REG_DAC:
          dac_ctl <= nibble_update(dac_ctl, frame_data);
        `REG_ADC:
          adc_ctl <= nibble_update(adc_ctl, frame_data);
        // back to the reset state
        // 4094 enable is left as is
        `REG_SOFT_RESET:
        begin
          led     <= '0;
          spi_mux <= '0;
          dac_ctl <= `DAC_RESET_VALUE;
          adc_ctl <= '0;
        end
        // rails up, dac already configured so leave it
        `REG_POWERUP:
        begin
          led     <= '0;
          adc_ctl <= '0;
        end
        default:
        begin
          // unmapped address, frame dropped
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // readback

  // nibble registers zero extended, commands read as 0
  always_comb
  begin
    case (frame_addr)
      `REG_LED:     rd_mux = {4'b0000, led};
      `REG_SPI_MUX: rd_mux = spi_mux;
      `REG_4094:    rd_mux = {4'b0000, oe_4094};
      `REG_DAC:     rd_mux = {4'b0000, dac_ctl};
      `REG_ADC:     rd_mux = {4'b0000, adc_ctl};
      default:      rd_mux = 8'h00;
    endcase
  end

  // captured once the address byte is in
  // receiver loads it on the following cycle
  always_ff @(posedge clk)
  begin
    if (addr_valid)
      rd_data <= rd_mux;
  end

endmodule

// ==== hdl/periph_spi_router.sv ====
////////////////////////////////////////////////////////////
// peripheral spi router
// drives the peripheral chip selects from cs2 and the mux
// register, and picks the miso source
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "spi_bank_cfg.svh"

module periph_spi_router (
  input  logic       cs2,
  input  logic [7:0] spi_mux,
  input  logic [7:0] periph_miso,
  input  logic       sdo,
  output logic [7:0] periph_cs,
  output logic       miso
);

  import spi_bank_pkg::*;

  localparam logic [7:0] CS_POLARITY = `PERIPH_CS_POLARITY;

  nibble_t    sel_num;
  logic       sel_valid;
  logic [2:0] line_idx;
  logic [7:0] line_active;

  // mux value n in 1..8 picks line n-1, anything else none
  assign sel_num   = spi_mux[3:0];
  assign sel_valid = (spi_mux[7:4] == 4'd0) && (sel_num != 4'd0) && (sel_num <= 4'd8);
  assign line_idx  = 3'(sel_num - 4'd1);

  // one hot, only while cs2 is asserted (low)
  assign line_active = (sel_valid && !cs2) ? (8'd1 << line_idx) : 8'd0;

  // flip per polarity bit
  // idle lines sit at the opposite of their active level
  assign periph_cs = ~(line_active ^ CS_POLARITY);

  // bank readback when cs2 idle
  always_comb
  begin
    if (cs2)
      miso = sdo;
    else if (sel_valid)
      miso = periph_miso[line_idx];
    else
      miso = 1'b0;
  end

endmodule

// ==== hdl/spi_bank_cfg.svh ====
////////////////////////////////////////////////////////////
// spi control bank configuration
// register map, frame size, chip select polarity and the
// values loaded at reset
////////////////////////////////////////////////////////////

`ifndef SPI_BANK_CFG_SVH
`define SPI_BANK_CFG_SVH

// host frame is address byte then data byte
`define SPI_FRAME_BITS      16

// register map, first byte of a frame
`define REG_POWERUP         8'd6
`define REG_LED             8'd7
`define REG_SPI_MUX         8'd8
`define REG_4094            8'd9
`define REG_DAC             8'd10
`define REG_SOFT_RESET      8'd11
`define REG_ADC             8'd14

// 1 marks an active high line, e.g. the 4094 strobes
`define PERIPH_CS_POLARITY  8'b0111_0000

// dac control idles with all lines high
`define DAC_RESET_VALUE     4'b1111

`endif

// ==== hdl/spi_bank_pkg.sv ====
////////////////////////////////////////////////////////////
// spi control bank types
// control register value and the two views of the
// frame data byte
////////////////////////////////////////////////////////////

package spi_bank_pkg;

  // one 4-bit control register
  typedef logic [3:0] nibble_t;

  // data byte as clear/set halves
  // upper nibble clears, lower nibble sets
  typedef struct packed {
    nibble_t clear;
    nibble_t set;
  } set_clear_t;

  //////////////////////////////////////////////////////////
  // frame data byte
  //////////////////////////////////////////////////////////

  // raw view for the mux register
  // sc view for the nibble registers
  typedef union packed {
    logic [7:0] raw;
    set_clear_t sc;
  } frame_data_u;

endpackage

// ==== hdl/spi_ctrl_top.sv ====
////////////////////////////////////////////////////////////
// spi board control top
// register bank on cs, peripheral pass-through on cs2
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module spi_ctrl_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  sclk,
  input  logic                  cs,
  input  logic                  mosi,
  input  logic                  cs2,
  input  logic [7:0]            periph_miso,
  output logic                  miso,
  output logic [7:0]            periph_cs,
  output logic                  periph_sclk,
  output logic                  periph_mosi,
  output spi_bank_pkg::nibble_t led,
  output spi_bank_pkg::nibble_t oe_4094,
  output spi_bank_pkg::nibble_t dac_ctl,
  output spi_bank_pkg::nibble_t adc_ctl
);

  // receiver to bank
  logic       addr_valid;
  logic       frame_valid;
  logic [7:0] frame_addr;
  logic [7:0] frame_data;
  logic [7:0] rd_data;
  // bank readback serial out
  logic       sdo;
  logic [7:0] spi_mux;

  // host clock and data go to every peripheral
  assign periph_sclk = sclk;
  assign periph_mosi = mosi;

  spi_frame_rx u_rx (
    .clk         (clk),
    .rst         (rst),
    .sclk        (sclk),
    .cs          (cs),
    .mosi        (mosi),
    .rd_data     (rd_data),
    .sdo         (sdo),
    .addr_valid  (addr_valid),
    .frame_valid (frame_valid),
    .frame_addr  (frame_addr),
    .frame_data  (frame_data)
  );

  ctrl_reg_bank u_bank (
    .clk         (clk),
    .rst         (rst),
    .frame_valid (frame_valid),
    .addr_valid  (addr_valid),
    .frame_addr  (frame_addr),
    .frame_data  (frame_data),
    .rd_data     (rd_data),
    .spi_mux     (spi_mux),
    .led         (led),
    .oe_4094     (oe_4094),
    .dac_ctl     (dac_ctl),
    .adc_ctl     (adc_ctl)
  );

  periph_spi_router u_router (
    .cs2         (cs2),
    .spi_mux     (spi_mux),
    .periph_miso (periph_miso),
    .sdo         (sdo),
    .periph_cs   (periph_cs),
    .miso        (miso)
  );

endmodule

// ==== hdl/spi_frame_rx.sv ====
////////////////////////////////////////////////////////////
// spi frame receiver
// samples the host spi pins in the clk domain, collects
// address/data frames and shifts readback bits out
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "spi_bank_cfg.svh"

module spi_frame_rx (
  input  logic       clk,
  input  logic       rst,
  input  logic       sclk,
  input  logic       cs,
  input  logic       mosi,
  input  logic [7:0] rd_data,
  output logic       sdo,
  output logic       addr_valid,
  output logic       frame_valid,
  output logic [7:0] frame_addr,
  output logic [7:0] frame_data
);

  import spi_bank_pkg::*;

  localparam int FRAME_BITS = `SPI_FRAME_BITS;
  // one byte is two control nibbles
  localparam int BYTE_BITS  = 2 * $bits(nibble_t);

  // synchronizer stages, oldest bit on the left
  logic [2:0]            sclk_sync;
  logic [2:0]            cs_sync;
  logic [1:0]            mosi_sync;

  logic                  sclk_rise;
  logic                  sclk_fall;
  logic                  cs_rise;
  logic                  cs_idle;
  logic                  mosi_bit;
  logic                  addr_done;

  // frame state
  logic [4:0]            bit_cnt;
  logic [FRAME_BITS-1:0] rx_shift;
  logic [FRAME_BITS-1:0] rx_next;
  logic [BYTE_BITS-1:0]  tx_shift;
  logic                  tx_load;

  ////////////////////////////////////////////////////////////
  // pin synchronizers

  // cs resets to idle (high)
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sclk_sync <= '0;
      cs_sync   <= '1;
    end
    else
    begin
      sclk_sync <= {sclk_sync[1:0], sclk};
      cs_sync   <= {cs_sync[1:0], cs};
    end
  end

  // mosi only two deep, lines up with sclk_sync[1]
  always_ff @(posedge clk)
  begin
    mosi_sync <= {mosi_sync[0], mosi};
  end

  // edge detect on synced copies
  assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
  assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
  assign cs_rise   = cs_sync[1] & ~cs_sync[2];
  assign cs_idle   = cs_sync[1];
  assign mosi_bit  = mosi_sync[1];

  // msb first, new bit enters at the bottom
  assign rx_next   = {rx_shift[FRAME_BITS-2:0], mosi_bit};
  // 8th rising edge completes the address byte
  assign addr_done = ~cs_idle & sclk_rise & (bit_cnt == 5'(BYTE_BITS - 1));

  ////////////////////////////////////////////////////////////
  // input shifter and bit count

  // held clear while cs is high, so a bad frame leaves nothing behind
  always_ff @(posedge clk)
  begin
    if (rst || cs_idle)
    begin
      bit_cnt  <= '0;
      rx_shift <= '0;
    end
    else if (sclk_rise)
    begin
      rx_shift <= rx_next;
      // saturate, long frames must not wrap back to 16
      if (bit_cnt != 5'd31)
        bit_cnt <= bit_cnt + 5'd1;
    end
  end

  // strobes to the bank
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      addr_valid  <= 1'b0;
      frame_valid <= 1'b0;
      tx_load     <= 1'b0;
    end
    else
    begin
      addr_valid  <= addr_done;
      // only an exact 16 bit frame is accepted
      frame_valid <= cs_rise & (bit_cnt == 5'(FRAME_BITS));
      // bank answers one cycle after addr_valid
      tx_load     <= addr_valid;
    end
  end

  // address held from the 8th edge through the frame strobe
  always_ff @(posedge clk)
  begin
    if (addr_done)
      frame_addr <= rx_next[BYTE_BITS-1:0];
    if (cs_rise)
      frame_data <= rx_shift[BYTE_BITS-1:0];
  end

  ////////////////////////////////////////////////////////////
  // readback shifter

  // zeros out unless a read value was loaded
  // new bit after each falling sclk, msb first
  always_ff @(posedge clk)
  begin
    if (rst || cs_idle)
    begin
      tx_shift <= '0;
      sdo      <= 1'b0;
    end
    else if (tx_load)
      tx_shift <= rd_data;
    else if (sclk_fall)
    begin
      sdo      <= tx_shift[BYTE_BITS-1];
      tx_shift <= {tx_shift[BYTE_BITS-2:0], 1'b0};
    end
  end

endmodule

// ==== verif/spi_ctrl_cases.txt ====
// op_addr_data_nbits_led_oe_dac_adc_mux_rd_pmiso_pcs_miso, all hex, nbits 10 = 16 bits
// op 0 check only, 1 write frame, 2 read frame (rd checked), 3 mux write then cs2 low
0_00_00_00_0_0_f_0_00_00_00_8f_0
1_07_05_10_5_0_f_0_00_00_00_8f_0
1_07_10_10_4_0_f_0_00_00_00_8f_0
1_07_66_10_2_0_f_0_00_00_00_8f_0
1_09_0f_10_2_f_f_0_00_00_00_8f_0
1_09_a1_10_2_5_f_0_00_00_00_8f_0
1_0a_30_10_2_5_c_0_00_00_00_8f_0
1_0a_99_10_2_5_5_0_00_00_00_8f_0
1_0e_06_10_2_5_5_6_00_00_00_8f_0
1_0e_53_10_2_5_5_7_00_00_00_8f_0
1_08_5a_10_2_5_5_7_5a_00_00_8f_0
2_07_00_10_2_5_5_7_5a_02_00_8f_0
2_09_00_10_2_5_5_7_5a_05_00_8f_0
2_0a_00_10_2_5_5_7_5a_05_00_8f_0
2_0e_00_10_2_5_5_7_5a_07_00_8f_0
2_08_5a_10_2_5_5_7_5a_5a_00_8f_0
2_0c_00_10_2_5_5_7_5a_00_00_8f_0
1_07_0f_0f_2_5_5_7_5a_00_00_8f_0
1_0e_0f_11_2_5_5_7_5a_00_00_8f_0
1_06_00_10_0_5_5_0_5a_00_00_8f_0
1_07_0f_10_f_5_5_0_5a_00_00_8f_0
1_0b_00_10_0_5_f_0_00_00_00_8f_0
3_08_00_10_0_5_f_0_00_00_ff_8f_0
3_08_01_10_0_5_f_0_01_00_01_8e_1
3_08_02_10_0_5_f_0_02_00_02_8d_1
3_08_03_10_0_5_f_0_03_00_fb_8b_0
3_08_04_10_0_5_f_0_04_00_f7_87_0
3_08_05_10_0_5_f_0_05_00_10_9f_1
3_08_06_10_0_5_f_0_06_00_20_af_1
3_08_07_10_0_5_f_0_07_00_bf_cf_0
3_08_08_10_0_5_f_0_08_00_80_0f_1
2_08_08_10_0_5_f_0_08_08_00_8f_0

// ==== verif/tb_spi_ctrl.sv ====
////////////////////////////////////////////////////////////
// spi control bank testbench
// plays the case file as serial spi frames and checks the
// registers, peripheral pins and miso
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_spi_ctrl;

  // clk periods per sclk half
  localparam int HALF_CYCLES = 8;
  localparam int MAX_CASES   = 64;

  logic       clk;
  logic       rst;
  logic       sclk;
  logic       cs;
  logic       mosi;
  logic       cs2;
  logic [7:0] periph_miso;
  logic       miso;
  logic [7:0] periph_cs;
  logic       periph_sclk;
  logic       periph_mosi;
  logic [3:0] led;
  logic [3:0] oe_4094;
  logic [3:0] dac_ctl;
  logic [3:0] adc_ctl;

  // one 80 bit word per case line
  logic [79:0] cases [MAX_CASES];
  logic [7:0]  rd_byte;
  int          errors;
  int          checks;

  spi_ctrl_top dut (
    .clk         (clk),
    .rst         (rst),
    .sclk        (sclk),
    .cs          (cs),
    .mosi        (mosi),
    .cs2         (cs2),
    .periph_miso (periph_miso),
    .miso        (miso),
    .periph_cs   (periph_cs),
    .periph_sclk (periph_sclk),
    .periph_mosi (periph_mosi),
    .led         (led),
    .oe_4094     (oe_4094),
    .dac_ctl     (dac_ctl),
    .adc_ctl     (adc_ctl)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // helpers

  // bounded clock count, lands 1 ns past the edge
  task automatic wait_cycles(input int n);
    for (int i = 0; i < n; i++)
      @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string what, input logic [7:0] got,
                             input logic [7:0] exp, input int idx);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch at %0t: case %0d %s got %h expected %h",
               $time, idx, what, got, exp);
    end
  endtask

  // host sclk and mosi reach the peripheral pins unchanged
  task automatic check_fanout(input int idx);
    check_value("periph_sclk", {7'h00, periph_sclk}, {7'h00, sclk}, idx);
    check_value("periph_mosi", {7'h00, periph_mosi}, {7'h00, mosi}, idx);
  endtask

  // mode 0 frame, msb first, nbits may be short or long
  // miso taken at each rising sclk of the data byte
  task automatic send_frame(input logic [7:0] addr, input logic [7:0] data,
                            input logic [7:0] nbits, input int idx);
    logic [31:0] word;
    word    = {addr, data, 16'h0000};
    rd_byte = 8'h00;
    cs      = 1'b0;
    for (int i = 0; i < int'(nbits); i++)
    begin
      mosi = word[31 - i];
      wait_cycles(HALF_CYCLES);
      if (i >= 8 && i < 16)
        rd_byte = {rd_byte[6:0], miso};
      check_fanout(idx);
      sclk = 1'b1;
      wait_cycles(HALF_CYCLES);
      check_fanout(idx);
      sclk = 1'b0;
    end
    mosi = 1'b0;
    wait_cycles(HALF_CYCLES);
    cs = 1'b1;
    // update lands 4 edges after cs, allow 10
    wait_cycles(10);
  endtask

  ////////////////////////////////////////////////////////////
  // case player

  initial
  begin
    logic [79:0] c;
    int          idx;
    errors      = 0;
    checks      = 0;
    rst         = 1'b1;
    sclk        = 1'b0;
    cs          = 1'b1;
    mosi        = 1'b0;
    cs2         = 1'b1;
    periph_miso = 8'h00;
    // op f marks the end of the loaded lines
    for (int i = 0; i < MAX_CASES; i++)
      cases[i] = '1;
    $readmemh("verif/spi_ctrl_cases.txt", cases);
    wait_cycles(8);
    rst = 1'b0;
    wait_cycles(2);
    idx = 0;
    while (idx < MAX_CASES && cases[idx][79:76] !== 4'hf)
    begin
      c = cases[idx];
      if (c[79:76] == 4'h1 || c[79:76] == 4'h2 || c[79:76] == 4'h3)
        send_frame(c[75:68], c[67:60], c[59:52], idx);
      // pass-through with the new mux value
      if (c[79:76] == 4'h3)
      begin
        cs2         = 1'b0;
        periph_miso = c[19:12];
        wait_cycles(1);
      end
      check_value("led", {4'h0, led}, {4'h0, c[51:48]}, idx);
      check_value("oe_4094", {4'h0, oe_4094}, {4'h0, c[47:44]}, idx);
      check_value("dac_ctl", {4'h0, dac_ctl}, {4'h0, c[43:40]}, idx);
      check_value("adc_ctl", {4'h0, adc_ctl}, {4'h0, c[39:36]}, idx);
      check_value("spi_mux", dut.spi_mux, c[35:28], idx);
      if (c[79:76] == 4'h2)
        check_value("readback", rd_byte, c[27:20], idx);
      check_value("periph_cs", periph_cs, c[11:4], idx);
      check_value("miso", {7'h00, miso}, {4'h0, c[3:0]}, idx);
      cs2         = 1'b1;
      periph_miso = 8'h00;
      idx++;
    end
    if (idx == 0)
    begin
      errors++;
      $display("no test cases could be read from the case file");
    end
    $display("cases: %0d  checks: %0d  errors: %0d", idx, checks, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+hdl
hdl/spi_bank_pkg.sv
hdl/spi_frame_rx.sv
hdl/ctrl_reg_bank.sv
hdl/periph_spi_router.sv
hdl/spi_ctrl_top.sv
verif/tb_spi_ctrl.sv
